// File: verif/dualcore_sys_testdata.hex
// columns: op, address, write data, expected read data, expected response
// op 0 read, 1 write, f end of data; response 0 okay, 2 slave error, 3 decode error
1 F0000000 0000003A 00000000 0
0 F0000000 00000000 0000000A 0
1 F0000004 DEADBEEF 00000000 0
0 F0000004 00000000 DEADBEEF 0
0 F0000008 00000000 000000A0 0
1 F0000008 12345678 00000000 2
0 F000000C 00000000 00000000 2
// fill the queue
1 F1000000 11110001 00000000 0
1 F1000000 11110002 00000000 0
1 F1000000 11110003 00000000 0
1 F1000000 11110004 00000000 0
1 F1000000 11110005 00000000 0
1 F1000000 11110006 00000000 0
1 F1000000 11110007 00000000 0
1 F1000000 11110008 00000000 0
0 F1000004 00000000 00000008 0
1 F1000000 99999999 00000000 2
0 F1000004 00000000 00000008 0
0 F0000008 00000000 000000A1 0
// drain in push order, then underflow
0 F1000000 00000000 11110001 0
0 F1000000 00000000 11110002 0
0 F1000000 00000000 11110003 0
0 F1000000 00000000 11110004 0
0 F1000000 00000000 11110005 0
0 F1000000 00000000 11110006 0
0 F1000000 00000000 11110007 0
0 F1000000 00000000 11110008 0
0 F1000004 00000000 00000000 0
0 F1000000 00000000 00000000 2
// outside both windows, state must not move
0 00000000 00000000 00000000 3
1 F0001000 00000005 00000000 3
0 F0000000 00000000 0000000A 0
1 F1000008 00000001 00000000 2
F 00000000 00000000 00000000 0

// File: dualcore_sys.f
design/sys_pkg.sv
design/reset_sequencer.sv
design/bus_decoder.sv
design/sys_regs.sv
design/msg_queue.sv
design/dualcore_sys.sv
verif/dualcore_sys_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile with Verilator and run the testbench from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module dualcore_sys_tb -f dualcore_sys.f \
	-o dualcore_sys_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/dualcore_sys_sim > sim.log 2>&1
cat sim.log
grep -q "^All tests passed$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: verif/dualcore_sys_tb.sv
// testbench for dualcore_sys; replays the testdata file over the bus and checks responses, LEDs and irq
`default_nettype none

module dualcore_sys_tb;

	import sys_pkg::*;

	localparam int RESET_HOLD       = 16;
	localparam int QUEUE_DEPTH_BITS = 3;
	localparam int QUEUE_DEPTH      = 2 ** QUEUE_DEPTH_BITS;
	localparam int MAX_TRANS        = 64;
	localparam int FIELDS           = 5;
	localparam int WAIT_LIMIT       = 64;

	logic  core_clk;
	logic  rst_n;
	logic  i_req_valid;
	logic  i_req_write;
	addr_t i_req_addr;
	word_t i_req_wdata;
	logic  o_req_ready;
	logic  o_rsp_valid;
	word_t o_rsp_rdata;
	resp_e o_rsp_resp;
	logic  i_rsp_ready;
	led_t  o_led;
	logic  o_irq;

	word_t       testdata [MAX_TRANS*FIELDS];
	int          n_trans;
	int          cycle_limit = 0;
	int          cycle_count = 0;
	int          mismatch_count = 0;
	int          protocol_count = 0;
	logic [31:0] rand_state;
	led_t        exp_led;
	int          exp_count;

	dualcore_sys #(
		.RESET_HOLD       (RESET_HOLD),
		.QUEUE_DEPTH_BITS (QUEUE_DEPTH_BITS)
	) dut (
		.core_clk    (core_clk),
		.rst_n       (rst_n),
		.i_req_valid (i_req_valid),
		.i_req_write (i_req_write),
		.i_req_addr  (i_req_addr),
		.i_req_wdata (i_req_wdata),
		.o_req_ready (o_req_ready),
		.o_rsp_valid (o_rsp_valid),
		.o_rsp_rdata (o_rsp_rdata),
		.o_rsp_resp  (o_rsp_resp),
		.i_rsp_ready (i_rsp_ready),
		.o_led       (o_led),
		.o_irq       (o_irq)
	);

	always #2 core_clk = ~core_clk;

	// run length guard
	always @(posedge core_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("timeout: run stopped at cycle %0d, %0d value errors, %0d protocol errors",
				cycle_count, mismatch_count, protocol_count);
			$display("Some tests failed");
			$finish;
		end
	end

	function automatic logic [31:0] next_random(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic regs_hit(input addr_t addr);
		return addr[31:WINDOW_BITS] == REGS_BASE[31:WINDOW_BITS];
	endfunction

	function automatic logic queue_hit(input addr_t addr);
		return addr[31:WINDOW_BITS] == QUEUE_BASE[31:WINDOW_BITS];
	endfunction

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			mismatch_count++;
			$display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_resp(input resp_e got, input resp_e exp, input string what);
		if (got !== exp) begin
			mismatch_count++;
			$display("Fail %0t: %s is %0d (%s), expected %0d (%s)", $time, what,
				got, got.name(), exp, exp.name());
		end
	endtask

	task automatic check_led(input led_t got, input led_t exp, input string what);
		if (got !== exp) begin
			mismatch_count++;
			$display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// expected LED pattern and queue fill, from the register and queue rules
	task automatic update_model(input logic wr, input addr_t addr, input word_t wdata);
		logic [WINDOW_BITS-1:0] ofs;
		ofs = addr[WINDOW_BITS-1:0];
		if (regs_hit(addr) && wr && ofs == OFS_LED) begin
			exp_led = wdata[3:0];
		end
		// pushes past full and pops of an empty queue are dropped
		if (queue_hit(addr) && ofs == OFS_QDATA) begin
			if (wr && exp_count < QUEUE_DEPTH) begin
				exp_count++;
			end else if (!wr && exp_count > 0) begin
				exp_count--;
			end
		end
	endtask

	// entered on the falling edge where rst_n is released
	task automatic measure_reset_hold();
		int low_cycles;
		low_cycles = 0;
		rst_n = 1'b1;
		while (!o_req_ready && low_cycles <= RESET_HOLD + WAIT_LIMIT) begin
			@(negedge core_clk);
			if (!o_req_ready) begin
				low_cycles++;
			end
			check_led(o_led, '0, "LEDs during reset hold");
			check_led({3'b0, o_irq}, '0, "irq during reset hold");
			if (o_rsp_valid) begin
				protocol_count++;
				$display("response valid raised during the reset hold");
			end
		end
		if (!o_req_ready) begin
			protocol_count++;
			$display("request ready never rose after reset release");
		end
		check_word(word_t'(low_cycles), word_t'(RESET_HOLD), "cycles with ready low after reset");
	endtask

	// one bus transaction from testdata line idx, entered on a falling edge
	task automatic run_transaction(input int idx);
		logic  wr;
		addr_t addr;
		word_t wdata;
		word_t exp_rdata;
		resp_e exp_resp;
		word_t held_rdata;
		resp_e held_resp;
		int    waited;
		int    hold;
		string tag;

		wr        = testdata[idx*FIELDS][0];
		addr      = testdata[idx*FIELDS+1];
		wdata     = testdata[idx*FIELDS+2];
		exp_rdata = testdata[idx*FIELDS+3];
		exp_resp  = resp_e'(testdata[idx*FIELDS+4][1:0]);
		tag       = $sformatf("transaction %0d at %h", idx, addr);

		i_req_valid = 1'b1;
		i_req_write = wr;
		i_req_addr  = addr;
		i_req_wdata = wdata;
		waited = 0;
		while (!o_req_ready && waited < WAIT_LIMIT) begin
			@(negedge core_clk);
			waited++;
		end
		if (!o_req_ready) begin
			protocol_count++;
			$display("%s was not accepted within %0d cycles", tag, WAIT_LIMIT);
			i_req_valid = 1'b0;
			return;
		end
		// taken on the rising edge in between
		@(negedge core_clk);
		i_req_valid = 1'b0;

		waited = 0;
		while (!o_rsp_valid && waited < WAIT_LIMIT) begin
			@(negedge core_clk);
			waited++;
		end
		if (!o_rsp_valid) begin
			protocol_count++;
			$display("%s got no response within %0d cycles", tag, WAIT_LIMIT);
			return;
		end
		held_rdata = o_rsp_rdata;
		held_resp  = o_rsp_resp;

		// random back-pressure, response must hold still
		rand_state = next_random(rand_state);
		hold = int'(rand_state[17:15]);
		repeat (hold) begin
			@(negedge core_clk);
			if (!o_rsp_valid) begin
				protocol_count++;
				$display("%s dropped its response while i_rsp_ready was low", tag);
			end
			if (o_req_ready) begin
				protocol_count++;
				$display("%s: a new request could be taken while still in ST_RESPOND", tag);
			end
			check_word(o_rsp_rdata, held_rdata, {tag, " held read data"});
			check_resp(o_rsp_resp, held_resp, {tag, " held response"});
		end
		i_rsp_ready = 1'b1;
		@(negedge core_clk);
		i_rsp_ready = 1'b0;
		if (o_rsp_valid) begin
			protocol_count++;
			$display("%s kept its response valid after it was taken", tag);
		end

		check_word(held_rdata, exp_rdata, {tag, " read data"});
		check_resp(held_resp, exp_resp, {tag, " response"});
		update_model(wr, addr, wdata);
		if (!wr && queue_hit(addr) && addr[WINDOW_BITS-1:0] == OFS_QCOUNT) begin
			check_word(held_rdata, word_t'(exp_count), {tag, " count against model"});
		end
		check_led(o_led, exp_led, {tag, " LEDs"});
		check_led({3'b0, o_irq}, {3'b0, exp_count != 0}, {tag, " irq"});
	endtask

	initial begin
		core_clk    = 1'b0;
		rst_n       = 1'b0;
		i_req_valid = 1'b0;
		i_req_write = 1'b0;
		i_req_addr  = '0;
		i_req_wdata = '0;
		i_rsp_ready = 1'b0;
		rand_state  = 32'h50f5993a;
		exp_led     = '0;
		exp_count   = 0;

		$readmemh("verif/dualcore_sys_testdata.hex", testdata);
		n_trans = 0;
		while (n_trans < MAX_TRANS && testdata[n_trans*FIELDS] != 32'hF) begin
			n_trans++;
		end
		if (n_trans == MAX_TRANS) begin
			protocol_count++;
			$display("testdata file has no end marker, no transactions run");
			n_trans = 0;
		end
		cycle_limit = n_trans * 80 + RESET_HOLD + 50;

		repeat (5) @(negedge core_clk);
		measure_reset_hold();
		for (int t = 0; t < n_trans; t++) begin
			run_transaction(t);
		end

		$display("%0d transactions, %0d value errors, %0d protocol errors",
			n_trans, mismatch_count, protocol_count);
		if (mismatch_count == 0 && protocol_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: design/dualcore_sys.sv
// system block top; reset sequencer, bus decoder, system registers and message queue
`default_nettype none

module dualcore_sys #(
	parameter int RESET_HOLD       = 16,
	parameter int QUEUE_DEPTH_BITS = 3
) (
	input  logic           core_clk,
	input  logic           rst_n,
	// request channel
	input  logic           i_req_valid,
	input  logic           i_req_write,
	input  sys_pkg::addr_t i_req_addr,
	input  sys_pkg::word_t i_req_wdata,
	output logic           o_req_ready,
	// response channel
	output logic           o_rsp_valid,
	output sys_pkg::word_t o_rsp_rdata,
	output sys_pkg::resp_e o_rsp_resp,
	input  logic           i_rsp_ready,
	output sys_pkg::led_t  o_led,
	output logic           o_irq
);

	import sys_pkg::*;

	logic                   sys_rst_n;
	logic                   regs_stb;
	logic                   queue_stb;
	logic                   bus_wr;
	logic [WINDOW_BITS-1:0] bus_offset;
	word_t                  bus_wdata;
	word_t                  regs_rdata;
	logic                   regs_err;
	word_t                  queue_rdata;
	logic                   queue_err;

	reset_sequencer #(
		.RESET_HOLD (RESET_HOLD)
	) u_rst_seq (
		.core_clk    (core_clk),
		.rst_n       (rst_n),
		.o_sys_rst_n (sys_rst_n)
	);

	bus_decoder u_decoder (
		.core_clk      (core_clk),
		.i_sys_rst_n   (sys_rst_n),
		.i_req_valid   (i_req_valid),
		.i_req_write   (i_req_write),
		.i_req_addr    (i_req_addr),
		.i_req_wdata   (i_req_wdata),
		.o_req_ready   (o_req_ready),
		.o_rsp_valid   (o_rsp_valid),
		.o_rsp_rdata   (o_rsp_rdata),
		.o_rsp_resp    (o_rsp_resp),
		.i_rsp_ready   (i_rsp_ready),
		.o_regs_stb    (regs_stb),
		.o_queue_stb   (queue_stb),
		.o_wr          (bus_wr),
		.o_offset      (bus_offset),
		.o_wdata       (bus_wdata),
		.i_regs_rdata  (regs_rdata),
		.i_regs_err    (regs_err),
		.i_queue_rdata (queue_rdata),
		.i_queue_err   (queue_err)
	);

	sys_regs u_regs (
		.core_clk    (core_clk),
		.i_sys_rst_n (sys_rst_n),
		.i_stb       (regs_stb),
		.i_wr        (bus_wr),
		.i_offset    (bus_offset),
		.i_wdata     (bus_wdata),
		.i_irq       (o_irq),
		.o_rdata     (regs_rdata),
		.o_err       (regs_err),
		.o_led       (o_led)
	);

	msg_queue #(
		.QUEUE_DEPTH_BITS (QUEUE_DEPTH_BITS)
	) u_queue (
		.core_clk    (core_clk),
		.i_sys_rst_n (sys_rst_n),
		.i_stb       (queue_stb),
		.i_wr        (bus_wr),
		.i_offset    (bus_offset),
		.i_wdata     (bus_wdata),
		.o_rdata     (queue_rdata),
		.o_err       (queue_err),
		.o_irq       (o_irq)
	);

endmodule

`default_nettype wire

// File: design/msg_queue.sv
// message queue slave: word FIFO pushed and popped by strobe, irq raised while it holds data
`default_nettype none

module msg_queue #(
	parameter int QUEUE_DEPTH_BITS = 3
) (
	input  logic                            core_clk,
	input  logic                            i_sys_rst_n,
	input  logic                            i_stb,
	input  logic                            i_wr,
	input  logic [sys_pkg::WINDOW_BITS-1:0] i_offset,
	input  sys_pkg::word_t                  i_wdata,
	output sys_pkg::word_t                  o_rdata,
	output logic                            o_err,
	output logic                            o_irq
);

	import sys_pkg::*;

	localparam int DEPTH = 2 ** QUEUE_DEPTH_BITS;

	word_t                       mem [DEPTH];
	logic [QUEUE_DEPTH_BITS-1:0] wr_ptr;
	logic [QUEUE_DEPTH_BITS-1:0] rd_ptr;
	logic [QUEUE_DEPTH_BITS:0]   count;
	logic                        full;
	logic                        empty;
	logic                        push;
	logic                        pop;

	assign full  = (count == (QUEUE_DEPTH_BITS + 1)'(DEPTH));
	assign empty = (count == '0);

	// access decode, overflow and underflow drop the access and flag an error
	always_comb begin
		o_rdata = '0;
		o_err   = 1'b0;
		push    = 1'b0;
		pop     = 1'b0;
		case (i_offset)
			OFS_QDATA: begin
				if (i_wr) begin
					if (full) o_err = 1'b1;
					else push = i_stb;
				end else begin
					if (empty) begin
						o_err = 1'b1;
					end else begin
						o_rdata = mem[rd_ptr];
						pop     = i_stb;
					end
				end
			end
			OFS_QCOUNT: begin
				if (i_wr) o_err = 1'b1;
				else o_rdata = word_t'(count);
			end
			default: begin
				o_err = 1'b1;
			end
		endcase
	end

	// pointers wrap naturally at the power-of-two depth
	always_ff @(posedge core_clk) begin
		if (!i_sys_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
				count  <= count + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
				count  <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge core_clk) begin
		if (push) mem[wr_ptr] <= i_wdata;
	end

	assign o_irq = !empty;

endmodule

`default_nettype wire

// File: design/sys_regs.sv
// system register slave: LED, scratch and read-only status, accessed by a one-cycle strobe
`default_nettype none

module sys_regs (
	input  logic                            core_clk,
	input  logic                            i_sys_rst_n,
	input  logic                            i_stb,
	input  logic                            i_wr,
	input  logic [sys_pkg::WINDOW_BITS-1:0] i_offset,
	input  sys_pkg::word_t                  i_wdata,
	input  logic                            i_irq,
	output sys_pkg::word_t                  o_rdata,
	output logic                            o_err,
	output sys_pkg::led_t                   o_led
);

	import sys_pkg::*;

	led_t  led_q;
	word_t scratch_q;
	word_t status;
	logic  led_we;
	logic  scratch_we;

	// status layout: irq in bit 0, LEDs in 7:4
	assign status = {24'b0, led_q, 3'b0, i_irq};

	always_comb begin
		o_rdata    = '0;
		o_err      = 1'b0;
		led_we     = 1'b0;
		scratch_we = 1'b0;
		case (i_offset)
			OFS_LED: begin
				if (i_wr) led_we = i_stb;
				else o_rdata = {28'b0, led_q};
			end
			OFS_SCRATCH: begin
				if (i_wr) scratch_we = i_stb;
				else o_rdata = scratch_q;
			end
			OFS_STATUS: begin
				// read-only
				if (i_wr) o_err = 1'b1;
				else o_rdata = status;
			end
			default: begin
				o_err = 1'b1;
			end
		endcase
	end

	always_ff @(posedge core_clk) begin
		if (!i_sys_rst_n) begin
			led_q     <= '0;
			scratch_q <= '0;
		end else begin
			if (led_we) led_q <= i_wdata[3:0];
			if (scratch_we) scratch_q <= i_wdata;
		end
	end

	assign o_led = led_q;

endmodule

`default_nettype wire

// File: design/bus_decoder.sv
// single-master bus front end; decodes the address, strobes one slave and returns its response
`default_nettype none

module bus_decoder (
	input  logic                                core_clk,
	input  logic                                i_sys_rst_n,
	// request channel
	input  logic                                i_req_valid,
	input  logic                                i_req_write,
	input  sys_pkg::addr_t                      i_req_addr,
	input  sys_pkg::word_t                      i_req_wdata,
	output logic                                o_req_ready,
	// response channel
	output logic                                o_rsp_valid,
	output sys_pkg::word_t                      o_rsp_rdata,
	output sys_pkg::resp_e                      o_rsp_resp,
	input  logic                                i_rsp_ready,
	// slave side
	output logic                                o_regs_stb,
	output logic                                o_queue_stb,
	output logic                                o_wr,
	output logic [sys_pkg::WINDOW_BITS-1:0]     o_offset,
	output sys_pkg::word_t                      o_wdata,
	input  sys_pkg::word_t                      i_regs_rdata,
	input  logic                                i_regs_err,
	input  sys_pkg::word_t                      i_queue_rdata,
	input  logic                                i_queue_err
);

	import sys_pkg::*;

	bus_state_e             state_q;
	logic                   req_ready_q;
	logic                   wr_q;
	logic [WINDOW_BITS-1:0] offset_q;
	word_t                  wdata_q;
	target_e                target_q;
	word_t                  rsp_rdata_q;
	resp_e                  rsp_resp_q;
	word_t                  sel_rdata;
	logic                   sel_err;

	// upper 20 address bits pick the window
	function automatic target_e decode_target(input addr_t addr);
		if (addr[31:WINDOW_BITS] == REGS_BASE[31:WINDOW_BITS]) begin
			return TGT_REGS;
		end else if (addr[31:WINDOW_BITS] == QUEUE_BASE[31:WINDOW_BITS]) begin
			return TGT_QUEUE;
		end
		return TGT_NONE;
	endfunction

	// mux of the addressed slave's return path
	always_comb begin
		case (target_q)
			TGT_REGS: begin
				sel_rdata = i_regs_rdata;
				sel_err   = i_regs_err;
			end
			TGT_QUEUE: begin
				sel_rdata = i_queue_rdata;
				sel_err   = i_queue_err;
			end
			default: begin
				sel_rdata = '0;
				sel_err   = 1'b0;
			end
		endcase
	end

	// control FSM, ready is registered so it stays low through the reset hold
	always_ff @(posedge core_clk) begin
		if (!i_sys_rst_n) begin
			state_q     <= ST_IDLE;
			req_ready_q <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (i_req_valid && req_ready_q) begin
						req_ready_q <= 1'b0;
						state_q     <= ST_ACCESS;
					end else begin
						req_ready_q <= 1'b1;
					end
				end
				ST_ACCESS: begin
					state_q <= ST_RESPOND;
				end
				ST_RESPOND: begin
					if (i_rsp_ready) begin
						req_ready_q <= 1'b1;
						state_q     <= ST_IDLE;
					end
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// request latch and response capture
	always_ff @(posedge core_clk) begin
		if (state_q == ST_IDLE && i_req_valid && req_ready_q) begin
			wr_q     <= i_req_write;
			offset_q <= i_req_addr[WINDOW_BITS-1:0];
			wdata_q  <= i_req_wdata;
			target_q <= decode_target(i_req_addr);
		end
		if (state_q == ST_ACCESS) begin
			rsp_rdata_q <= wr_q ? '0 : sel_rdata;
			if (target_q == TGT_NONE) begin
				rsp_resp_q <= RESP_DECERR;
			end else begin
				rsp_resp_q <= sel_err ? RESP_SLVERR : RESP_OKAY;
			end
		end
	end

	assign o_req_ready = req_ready_q;
	assign o_rsp_valid = (state_q == ST_RESPOND);
	assign o_rsp_rdata = rsp_rdata_q;
	assign o_rsp_resp  = rsp_resp_q;

	assign o_regs_stb  = (state_q == ST_ACCESS) && (target_q == TGT_REGS);
	assign o_queue_stb = (state_q == ST_ACCESS) && (target_q == TGT_QUEUE);
	assign o_wr        = wr_q;
	assign o_offset    = offset_q;
	assign o_wdata     = wdata_q;

endmodule

`default_nettype wire

// File: design/reset_sequencer.sv
// one-shot reset release; keeps the system reset asserted for RESET_HOLD cycles after rst_n
`default_nettype none

module reset_sequencer #(
	parameter int RESET_HOLD = 16
) (
	input  logic core_clk,
	input  logic rst_n,
	output logic o_sys_rst_n
);

	import sys_pkg::*;

	localparam int CNT_W = (RESET_HOLD > 1) ? $clog2(RESET_HOLD) : 1;

	seq_state_e       state_q;
	logic [CNT_W-1:0] hold_cnt;

	// counting starts in the first cycle rst_n is seen high
	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			state_q  <= SEQ_HOLD;
			hold_cnt <= '0;
		end else begin
			case (state_q)
				SEQ_HOLD: begin
					if (hold_cnt == CNT_W'(RESET_HOLD - 1)) begin
						state_q <= SEQ_RUN;
					end else begin
						hold_cnt <= hold_cnt + 1'b1;
					end
				end
				// stays released until the next external reset
				default: begin
					state_q <= SEQ_RUN;
				end
			endcase
		end
	end

	assign o_sys_rst_n = (state_q == SEQ_RUN);

endmodule

`default_nettype wire

// File: design/sys_pkg.sv
// shared types, address map and enums for the system block; imported by every RTL module
`default_nettype none

package sys_pkg;

	// data and address words on the bus
	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;

	// four board LEDs
	typedef logic [3:0] led_t;

	// window base addresses, each window is 4 KiB
	localparam addr_t REGS_BASE  = 32'hF000_0000;
	localparam addr_t QUEUE_BASE = 32'hF100_0000;
	localparam int    WINDOW_BITS = 12;

	// system register offsets
	localparam logic [WINDOW_BITS-1:0] OFS_LED     = 12'h000;
	localparam logic [WINDOW_BITS-1:0] OFS_SCRATCH = 12'h004;
	localparam logic [WINDOW_BITS-1:0] OFS_STATUS  = 12'h008;

	// message queue offsets
	localparam logic [WINDOW_BITS-1:0] OFS_QDATA  = 12'h000;
	localparam logic [WINDOW_BITS-1:0] OFS_QCOUNT = 12'h004;

	// response codes follow the AXI encoding
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'd0,
		RESP_SLVERR = 2'd2,
		RESP_DECERR = 2'd3
	} resp_e;

	typedef enum logic [1:0] {
		TGT_REGS  = 2'd0,
		TGT_QUEUE = 2'd1,
		TGT_NONE  = 2'd2
	} target_e;

	typedef enum logic [1:0] {
		ST_IDLE    = 2'd0,
		ST_ACCESS  = 2'd1,
		ST_RESPOND = 2'd2
	} bus_state_e;

	typedef enum logic {
		SEQ_HOLD = 1'b0,
		SEQ_RUN  = 1'b1
	} seq_state_e;

endpackage

`default_nettype wire
